// ==== hw/vec_defs.svh ====
/*
 * Build-time sizes of the vector coprocessor.
 * VEC_NR_LANES must be a power of two and at least 2.
 * VEC_NR_ELEMS must be a multiple of VEC_NR_LANES with at least two
 * elements per lane, and a power of two.
 */
`ifndef VEC_DEFS_SVH
`define VEC_DEFS_SVH

// Lanes working in lockstep
`define VEC_NR_LANES 4
// Elements per vector register
`define VEC_NR_ELEMS 8
// Architectural vector registers
`define VEC_NR_VREGS 8
// Word address width of the memory port
`define VEC_ADDR_W 16

`endif

// ==== hw/vec_pkg.sv ====
/*
 * Types shared by the vector coprocessor.
 * The instruction is one 32-bit word with the opcode in the top two bits.
 * Opcode value 3 is not defined and is executed as VADD.
 */
`include "vec_defs.svh"

package vec_pkg;

  localparam int unsigned VREG_W = $clog2(`VEC_NR_VREGS);

  // Slots in the target, ready and done vectors
  localparam int unsigned PE_LANES = 0;
  localparam int unsigned PE_LOAD  = 1;
  localparam int unsigned PE_STORE = 2;

  typedef enum logic [1:0] {
    VADD = 2'd0,
    VLD  = 2'd1,
    VST  = 2'd2
  } vec_op_e;

  typedef logic [VREG_W-1:0] vreg_idx_t;
  typedef logic [31:0] elem_t;
  typedef logic [$clog2(`VEC_NR_ELEMS / `VEC_NR_LANES)-1:0] elem_idx_t;

  typedef struct packed {
    vec_op_e                 op;
    vreg_idx_t               vd;
    vreg_idx_t               vs1;
    vreg_idx_t               vs2;
    logic [29-3*VREG_W:0]    rsvd;
  } vec_arith_insn_t;

  // vr is the destination of VLD and the source of VST
  typedef struct packed {
    vec_op_e                       op;
    vreg_idx_t                     vr;
    logic [`VEC_ADDR_W-1:0]        base;
    logic [29-VREG_W-`VEC_ADDR_W:0] rsvd;
  } vec_mem_insn_t;

  typedef union packed {
    vec_arith_insn_t arith;
    vec_mem_insn_t   mem;
  } vec_insn_u;

  typedef struct packed {
    vec_insn_u  insn;
    logic [2:0] target;
  } vec_pe_req_t;

endpackage

// ==== hw/vec_ifs.sv ====
/*
 * Memory port and lane write port.
 * Memory port: req and its fields hold until gnt, and read data returns
 * with rvalid exactly one cycle after the grant.
 * Lane write port has no ready, a lane takes every write at once.
 */
`include "vec_defs.svh"

interface mem_port_if import vec_pkg::*; ();
  logic                   req;
  logic                   gnt;
  logic                   we;
  logic [`VEC_ADDR_W-1:0] addr;
  elem_t                  wdata;
  logic                   rvalid;
  elem_t                  rdata;

  modport master (output req, we, addr, wdata, input gnt, rvalid, rdata);
  modport slave (input req, we, addr, wdata, output gnt, rvalid, rdata);
endinterface

interface lane_wr_if import vec_pkg::*; ();
  logic      valid;
  vreg_idx_t vreg;
  elem_idx_t idx;
  elem_t     data;

  modport master (output valid, vreg, idx, data);
  modport slave (input valid, vreg, idx, data);
endinterface

// ==== hw/vec_sequencer.sv ====
/*
 * Decode, hazard check and issue of one instruction per cycle.
 * Every register an instruction names is held busy until its unit is done,
 * so RAW, WAR and WAW hazards all stall; so does a repeated source.
 * At most two instructions are owed a response at any time, which bounds
 * the completion queue to two entries.
 */
`include "vec_defs.svh"

module vec_sequencer import vec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  vec_insn_u   acc_req_i,
  input  logic        acc_req_valid_i,
  output logic        acc_req_ready_o,
  output logic        acc_resp_valid_o,
  input  logic        acc_resp_ready_i,
  output vec_pe_req_t pe_req_o,
  output logic        pe_valid_o,
  input  logic [2:0]  pe_ready_i,
  input  logic [2:0]  pe_done_i
);

  logic [2:0]                    target;
  logic [2:0]                    owner;
  logic [`VEC_NR_VREGS-1:0]      regs;
  logic [`VEC_NR_VREGS-1:0]      reg_busy;
  logic [2:0][`VEC_NR_VREGS-1:0] reg_mask_q;
  logic [2:0]                    pe_busy_q;
  logic [1:0]                    owed_q;
  logic [1:0]                    rsp_cnt_q;
  logic [1:0]                    nr_done;
  logic                          fire;
  logic                          resp_fire;

  // VST also goes to the lanes, but only the store unit reports done
  always_comb begin
    target = '0;
    owner  = '0;
    regs   = '0;
    case (acc_req_i.arith.op)
      VLD: begin
        target[PE_LOAD]        = 1'b1;
        owner[PE_LOAD]         = 1'b1;
        regs[acc_req_i.mem.vr] = 1'b1;
      end
      VST: begin
        target[PE_LANES]       = 1'b1;
        target[PE_STORE]       = 1'b1;
        owner[PE_STORE]        = 1'b1;
        regs[acc_req_i.mem.vr] = 1'b1;
      end
      default: begin
        target[PE_LANES]          = 1'b1;
        owner[PE_LANES]           = 1'b1;
        regs[acc_req_i.arith.vd]  = 1'b1;
        regs[acc_req_i.arith.vs1] = 1'b1;
        regs[acc_req_i.arith.vs2] = 1'b1;
      end
    endcase
  end

  always_comb begin
    reg_busy = '0;
    for (int p = 0; p < 3; p++) begin
      reg_busy |= reg_mask_q[p];
    end
  end

  assign acc_req_ready_o = ((target & ~pe_ready_i) == '0) && ((owner & pe_busy_q) == '0) &&
                           ((regs & reg_busy) == '0) && (owed_q < 2'd2);
  assign fire       = acc_req_valid_i && acc_req_ready_o;
  assign pe_valid_o = fire;
  assign pe_req_o   = '{insn: acc_req_i, target: target};

  assign nr_done          = 2'(pe_done_i[0]) + 2'(pe_done_i[1]) + 2'(pe_done_i[2]);
  assign acc_resp_valid_o = rsp_cnt_q != '0;
  assign resp_fire        = acc_resp_valid_o && acc_resp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pe_busy_q  <= '0;
      reg_mask_q <= '0;
      owed_q     <= '0;
      rsp_cnt_q  <= '0;
    end else begin
      for (int p = 0; p < 3; p++) begin
        if (pe_done_i[p]) begin
          pe_busy_q[p]  <= 1'b0;
          reg_mask_q[p] <= '0;
        end else if (fire && owner[p]) begin
          pe_busy_q[p]  <= 1'b1;
          reg_mask_q[p] <= regs;
        end
      end
      // Issued but not yet answered
      owed_q    <= owed_q + 2'(fire) - 2'(resp_fire);
      // Completions waiting for the core
      rsp_cnt_q <= rsp_cnt_q + nr_done - 2'(resp_fire);
    end
  end

endmodule

// ==== hw/vec_lane.sv ====
/*
 * One lane with its slice of every vector register.
 * VADD runs one element per cycle and reports done one cycle after the
 * last element. During VST the lane only streams its slice out and raises
 * no done. Load writes arrive at any time and are always accepted.
 */
`include "vec_defs.svh"

module vec_lane import vec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  vec_pe_req_t pe_req_i,
  input  logic        pe_valid_i,
  output logic        pe_ready_o,
  output logic        done_o,
  lane_wr_if.slave    ld_wr,
  output logic        st_valid_o,
  output elem_t       st_data_o,
  input  logic        st_ready_i
);

  localparam int unsigned SLICE = `VEC_NR_ELEMS / `VEC_NR_LANES;

  elem_t     vrf_q [`VEC_NR_VREGS][SLICE];
  vec_insn_u insn_q;
  elem_idx_t idx_q;
  logic      busy_q;
  logic      st_q;
  logic      done_q;
  logic      start;
  logic      last;
  logic      add_en;
  elem_t     sum;

  // A lane target with the store bit set means VST
  assign start  = pe_valid_i && pe_ready_o && pe_req_i.target[PE_LANES];
  assign last   = idx_q == elem_idx_t'(SLICE - 1);
  assign add_en = busy_q && !st_q;
  assign sum    = vrf_q[insn_q.arith.vs1][idx_q] + vrf_q[insn_q.arith.vs2][idx_q];

  assign pe_ready_o = !busy_q;
  assign done_o     = done_q;
  assign st_valid_o = busy_q && st_q;
  assign st_data_o  = vrf_q[insn_q.mem.vr][idx_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      st_q   <= 1'b0;
      idx_q  <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= add_en && last;
      if (start) begin
        busy_q <= 1'b1;
        st_q   <= pe_req_i.target[PE_STORE];
        idx_q  <= '0;
      end else if (add_en || (st_valid_o && st_ready_i)) begin
        idx_q <= idx_q + 1'b1;
        if (last) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // Hazard checks keep the add and load writes on different registers
  always_ff @(posedge clk_i) begin
    if (start) begin
      insn_q <= pe_req_i.insn;
    end
    if (add_en) begin
      vrf_q[insn_q.arith.vd][idx_q] <= sum;
    end
    if (ld_wr.valid) begin
      vrf_q[ld_wr.vreg][ld_wr.idx] <= ld_wr.data;
    end
  end

endmodule

// ==== hw/vec_load_unit.sv ====
/*
 * Vector load from consecutive word addresses starting at the base.
 * Reads are issued as fast as grants allow; data returns in order.
 * Done follows the write of the last element into its lane.
 */
`include "vec_defs.svh"

module vec_load_unit import vec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  vec_pe_req_t pe_req_i,
  input  logic        pe_valid_i,
  output logic        pe_ready_o,
  output logic        done_o,
  mem_port_if.master  mem,
  lane_wr_if.master   lane_wr [`VEC_NR_LANES]
);

  localparam int unsigned CNT_W  = $clog2(`VEC_NR_ELEMS) + 1;
  localparam int unsigned LANE_W = $clog2(`VEC_NR_LANES);

  logic [`VEC_ADDR_W-1:0] base_q;
  vreg_idx_t              vd_q;
  logic [CNT_W-1:0]       req_cnt_q;
  logic [CNT_W-1:0]       rsp_cnt_q;
  logic                   busy_q;
  logic                   done_q;
  logic                   start;
  logic                   last_rsp;

  assign start      = pe_valid_i && pe_ready_o && pe_req_i.target[PE_LOAD];
  assign pe_ready_o = !busy_q;
  assign done_o     = done_q;
  assign last_rsp   = mem.rvalid && (rsp_cnt_q == CNT_W'(`VEC_NR_ELEMS - 1));

  assign mem.req   = busy_q && (req_cnt_q < CNT_W'(`VEC_NR_ELEMS));
  assign mem.we    = 1'b0;
  assign mem.addr  = base_q + `VEC_ADDR_W'(req_cnt_q);
  assign mem.wdata = '0;

  // Element i goes to lane i mod lanes, slice index i / lanes
  for (genvar l = 0; l < `VEC_NR_LANES; l++) begin : gen_wr
    assign lane_wr[l].valid = mem.rvalid && (rsp_cnt_q[LANE_W-1:0] == LANE_W'(l));
    assign lane_wr[l].vreg  = vd_q;
    assign lane_wr[l].idx   = elem_idx_t'(rsp_cnt_q >> LANE_W);
    assign lane_wr[l].data  = mem.rdata;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      req_cnt_q <= '0;
      rsp_cnt_q <= '0;
    end else begin
      done_q <= last_rsp;
      if (start) begin
        busy_q    <= 1'b1;
        req_cnt_q <= '0;
        rsp_cnt_q <= '0;
      end else begin
        if (mem.req && mem.gnt) begin
          req_cnt_q <= req_cnt_q + 1'b1;
        end
        if (mem.rvalid) begin
          rsp_cnt_q <= rsp_cnt_q + 1'b1;
        end
        if (last_rsp) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      base_q <= pe_req_i.insn.mem.base;
      vd_q   <= pe_req_i.insn.mem.vr;
    end
  end

endmodule

// ==== hw/vec_store_unit.sv ====
/*
 * Vector store to consecutive word addresses starting at the base.
 * One row, one element from every lane, is taken once all lanes are
 * valid and written lane by lane. The lanes advance only when the last
 * word of the row is granted. Done follows the last grant.
 */
`include "vec_defs.svh"

module vec_store_unit import vec_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  vec_pe_req_t               pe_req_i,
  input  logic                      pe_valid_i,
  output logic                      pe_ready_o,
  output logic                      done_o,
  input  logic [`VEC_NR_LANES-1:0]  st_valid_i,
  input  elem_t [`VEC_NR_LANES-1:0] st_data_i,
  output logic                      st_ready_o,
  mem_port_if.master                mem
);

  localparam int unsigned CNT_W  = $clog2(`VEC_NR_ELEMS) + 1;
  localparam int unsigned LANE_W = $clog2(`VEC_NR_LANES);

  logic [`VEC_ADDR_W-1:0]    base_q;
  elem_t [`VEC_NR_LANES-1:0] row_q;
  logic [CNT_W-1:0]          wr_cnt_q;
  logic                      busy_q;
  logic                      row_full_q;
  logic                      done_q;
  logic                      start;
  logic                      take_row;
  logic                      wr_gnt;
  logic                      last_wr;

  assign start      = pe_valid_i && pe_ready_o && pe_req_i.target[PE_STORE];
  assign take_row   = busy_q && !row_full_q && (&st_valid_i);
  assign wr_gnt     = mem.req && mem.gnt;
  assign last_wr    = wr_gnt && (wr_cnt_q == CNT_W'(`VEC_NR_ELEMS - 1));
  assign pe_ready_o = !busy_q;
  assign done_o     = done_q;

  // Row is released to the lanes with the grant of its last word
  assign st_ready_o = wr_gnt && (wr_cnt_q[LANE_W-1:0] == '1);

  assign mem.req   = row_full_q;
  assign mem.we    = 1'b1;
  assign mem.addr  = base_q + `VEC_ADDR_W'(wr_cnt_q);
  assign mem.wdata = row_q[wr_cnt_q[LANE_W-1:0]];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      row_full_q <= 1'b0;
      done_q     <= 1'b0;
      wr_cnt_q   <= '0;
    end else begin
      done_q <= last_wr;
      if (start) begin
        busy_q   <= 1'b1;
        wr_cnt_q <= '0;
      end else begin
        if (wr_gnt) begin
          wr_cnt_q <= wr_cnt_q + 1'b1;
        end
        if (last_wr) begin
          busy_q <= 1'b0;
        end
      end
      if (take_row) begin
        row_full_q <= 1'b1;
      end else if (st_ready_o) begin
        row_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      base_q <= pe_req_i.insn.mem.base;
    end
    if (take_row) begin
      row_q <= st_data_i;
    end
  end

endmodule

// ==== hw/mem_arbiter.sv ====
/*
 * Round-robin arbiter of the load and store ports onto one memory port.
 * A request left waiting for its grant keeps the port, so the outward
 * fields stay stable. Read data always goes to the load port, since the
 * store unit never reads.
 */
`include "vec_defs.svh"

module mem_arbiter import vec_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  mem_port_if.slave              ld,
  mem_port_if.slave              st,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output logic [`VEC_ADDR_W-1:0] mem_addr_o,
  output elem_t                  mem_wdata_o,
  input  logic                   mem_gnt_i,
  input  logic                   mem_rvalid_i,
  input  elem_t                  mem_rdata_i
);

  // Select and priority, high means the store port
  logic sel;
  logic sel_q;
  logic prio_q;
  logic lock_q;

  always_comb begin
    if (lock_q) begin
      sel = sel_q;
    end else if (ld.req && st.req) begin
      sel = prio_q;
    end else begin
      sel = st.req;
    end
  end

  assign mem_req_o   = sel ? st.req : ld.req;
  assign mem_we_o    = sel ? st.we : ld.we;
  assign mem_addr_o  = sel ? st.addr : ld.addr;
  assign mem_wdata_o = sel ? st.wdata : ld.wdata;

  assign ld.gnt    = mem_gnt_i && !sel;
  assign st.gnt    = mem_gnt_i && sel;
  assign ld.rvalid = mem_rvalid_i;
  assign ld.rdata  = mem_rdata_i;
  assign st.rvalid = 1'b0;
  assign st.rdata  = '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q  <= 1'b0;
      prio_q <= 1'b0;
      lock_q <= 1'b0;
    end else begin
      sel_q  <= sel;
      lock_q <= mem_req_o && !mem_gnt_i;
      // The other side wins the next tie
      if (mem_req_o && mem_gnt_i) begin
        prio_q <= !sel;
      end
    end
  end

endmodule

// ==== hw/vec_top.sv ====
/*
 * Vector coprocessor top level with plain ports towards the core and
 * towards memory. One response pulse per accepted instruction, in order
 * of completion, carrying no data.
 * Memory must return read data exactly one cycle after the grant.
 */
`include "vec_defs.svh"

module vec_top import vec_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic [31:0]            acc_req_i,
  input  logic                   acc_req_valid_i,
  output logic                   acc_req_ready_o,
  output logic                   acc_resp_valid_o,
  input  logic                   acc_resp_ready_i,
  output logic                   mem_req_o,
  output logic                   mem_we_o,
  output logic [`VEC_ADDR_W-1:0] mem_addr_o,
  output logic [31:0]            mem_wdata_o,
  input  logic                   mem_gnt_i,
  input  logic                   mem_rvalid_i,
  input  logic [31:0]            mem_rdata_i
);

  vec_pe_req_t               pe_req;
  logic                      pe_valid;
  logic [2:0]                pe_ready;
  logic [2:0]                pe_done;
  logic [`VEC_NR_LANES-1:0]  lane_ready;
  logic [`VEC_NR_LANES-1:0]  st_valid;
  elem_t [`VEC_NR_LANES-1:0] st_data;
  logic                      st_ready;

  mem_port_if ld_mem ();
  mem_port_if st_mem ();
  lane_wr_if  lane_wr [`VEC_NR_LANES] ();

  vec_sequencer i_sequencer (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .acc_req_i        (acc_req_i       ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i),
    .pe_req_o         (pe_req          ),
    .pe_valid_o       (pe_valid        ),
    .pe_ready_i       (pe_ready        ),
    .pe_done_i        (pe_done         )
  );

  assign pe_ready[PE_LANES] = &lane_ready;

  // Lanes run in lockstep, lane 0 speaks for all on done
  for (genvar l = 0; l < `VEC_NR_LANES; l++) begin : gen_lanes
    if (l == 0) begin : gen_lead
      vec_lane i_lane (
        .clk_i      (clk_i             ),
        .rst_n_i    (rst_n_i           ),
        .pe_req_i   (pe_req            ),
        .pe_valid_i (pe_valid          ),
        .pe_ready_o (lane_ready[l]     ),
        .done_o     (pe_done[PE_LANES] ),
        .ld_wr      (lane_wr[l]        ),
        .st_valid_o (st_valid[l]       ),
        .st_data_o  (st_data[l]        ),
        .st_ready_i (st_ready          )
      );
    end else begin : gen_follow
      vec_lane i_lane (
        .clk_i      (clk_i        ),
        .rst_n_i    (rst_n_i      ),
        .pe_req_i   (pe_req       ),
        .pe_valid_i (pe_valid     ),
        .pe_ready_o (lane_ready[l]),
        .done_o     (             ),
        .ld_wr      (lane_wr[l]   ),
        .st_valid_o (st_valid[l]  ),
        .st_data_o  (st_data[l]   ),
        .st_ready_i (st_ready     )
      );
    end
  end

  vec_load_unit i_load_unit (
    .clk_i      (clk_i            ),
    .rst_n_i    (rst_n_i          ),
    .pe_req_i   (pe_req           ),
    .pe_valid_i (pe_valid         ),
    .pe_ready_o (pe_ready[PE_LOAD]),
    .done_o     (pe_done[PE_LOAD] ),
    .mem        (ld_mem           ),
    .lane_wr    (lane_wr          )
  );

  vec_store_unit i_store_unit (
    .clk_i      (clk_i             ),
    .rst_n_i    (rst_n_i           ),
    .pe_req_i   (pe_req            ),
    .pe_valid_i (pe_valid          ),
    .pe_ready_o (pe_ready[PE_STORE]),
    .done_o     (pe_done[PE_STORE] ),
    .st_valid_i (st_valid          ),
    .st_data_i  (st_data           ),
    .st_ready_o (st_ready          ),
    .mem        (st_mem            )
  );

  mem_arbiter i_mem_arbiter (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .ld           (ld_mem      ),
    .st           (st_mem      ),
    .mem_req_o    (mem_req_o   ),
    .mem_we_o     (mem_we_o    ),
    .mem_addr_o   (mem_addr_o  ),
    .mem_wdata_o  (mem_wdata_o ),
    .mem_gnt_i    (mem_gnt_i   ),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i )
  );

endmodule

// ==== bench/vec_sva.sv ====
/*
 * Protocol assertions bound to the coprocessor top level.
 * Memory request fields must hold while a request waits for its grant,
 * a response must hold until taken, and nothing is requested in reset.
 */
`include "vec_defs.svh"

module vec_sva (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   acc_resp_valid_o,
  input logic                   acc_resp_ready_i,
  input logic                   mem_req_o,
  input logic                   mem_gnt_i,
  input logic                   mem_we_o,
  input logic [`VEC_ADDR_W-1:0] mem_addr_o,
  input logic [31:0]            mem_wdata_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Waiting request keeps the port and its fields
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) &&
                                 $stable(mem_addr_o) && $stable(mem_wdata_o))
    else $error("memory request changed before its grant");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o)
    else $error("response valid dropped before ready");

  assert property (@(posedge clk_i) !rst_n_i |-> !mem_req_o && !acc_resp_valid_o)
    else $error("control output high during reset");

endmodule

bind vec_top vec_sva sva_i (
  .clk_i            (clk_i           ),
  .rst_n_i          (rst_n_i         ),
  .acc_resp_valid_o (acc_resp_valid_o),
  .acc_resp_ready_i (acc_resp_ready_i),
  .mem_req_o        (mem_req_o       ),
  .mem_gnt_i        (mem_gnt_i       ),
  .mem_we_o         (mem_we_o        ),
  .mem_addr_o       (mem_addr_o      ),
  .mem_wdata_o      (mem_wdata_o     )
);

// ==== bench/vec_tb.sv ====
/*
 * Testbench for the vector coprocessor top level.
 * Loads read words 0..511 and stores write words 512..1023. An in-flight
 * store and a later load therefore never touch the same word, since the
 * design orders registers but not memory.
 * Every register is loaded before random VADD or VST instructions use it.
 */
`include "vec_defs.svh"

module vec_tb import vec_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ELEMS    = `VEC_NR_ELEMS;
  localparam int MEM_SZ   = 1024;
  localparam int REGION   = 512 - ELEMS + 1;
  localparam int NR_INSNS = 60;

  logic                   clk_i;
  logic                   rst_n_i;
  logic [31:0]            acc_req_i;
  logic                   acc_req_valid_i;
  logic                   acc_req_ready_o;
  logic                   acc_resp_valid_o;
  logic                   acc_resp_ready_i;
  logic                   mem_req_o;
  logic                   mem_we_o;
  logic [`VEC_ADDR_W-1:0] mem_addr_o;
  logic [31:0]            mem_wdata_o;
  logic                   mem_gnt_i;
  logic                   mem_rvalid_i;
  logic [31:0]            mem_rdata_i;

  elem_t                  mem [MEM_SZ];
  elem_t                  ref_mem [MEM_SZ];
  elem_t                  ref_vrf [`VEC_NR_VREGS][ELEMS];
  logic [`VEC_ADDR_W-1:0] exp_addr [$];
  elem_t                  exp_data [$];
  int                     val_errs = 0;
  int                     other_errs = 0;
  int                     accepted = 0;
  int                     resp_cnt = 0;
  bit                     hold_resp = 1'b0;

  vec_top dut_i (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .acc_req_i        (acc_req_i       ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i),
    .mem_req_o        (mem_req_o       ),
    .mem_we_o         (mem_we_o        ),
    .mem_addr_o       (mem_addr_o      ),
    .mem_wdata_o      (mem_wdata_o     ),
    .mem_gnt_i        (mem_gnt_i       ),
    .mem_rvalid_i     (mem_rvalid_i    ),
    .mem_rdata_i      (mem_rdata_i     )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Multiplicative hash so every address bit changes the word
  function automatic elem_t fill_word(input int a);
    return (32'(a) * 32'h9e37_79b9) ^ 32'h00c3_5a00;
  endfunction

  function automatic logic [31:0] enc_add(input int vd, input int vs1, input int vs2);
    logic [31:0] w;
    w = '0;
    w[31:30] = VADD;
    w[29:27] = 3'(vd);
    w[26:24] = 3'(vs1);
    w[23:21] = 3'(vs2);
    return w;
  endfunction

  function automatic logic [31:0] enc_mem(input vec_op_e op, input int vr, input int base);
    logic [31:0] w;
    w = '0;
    w[31:30] = op;
    w[29:27] = 3'(vr);
    w[26 -: `VEC_ADDR_W] = `VEC_ADDR_W'(base);
    return w;
  endfunction

  // Program-order model of the register file and the memory image
  function automatic void ref_exec(input logic [31:0] w);
    int base;
    base = int'(w[26 -: `VEC_ADDR_W]);
    for (int e = 0; e < ELEMS; e++) begin
      case (w[31:30])
        2'd1: ref_vrf[w[29:27]][e] = ref_mem[(base + e) % MEM_SZ];
        2'd2: begin
          ref_mem[(base + e) % MEM_SZ] = ref_vrf[w[29:27]][e];
          exp_addr.push_back(`VEC_ADDR_W'(base + e));
          exp_data.push_back(ref_vrf[w[29:27]][e]);
        end
        default: ref_vrf[w[29:27]][e] = ref_vrf[w[26:24]][e] + ref_vrf[w[23:21]][e];
      endcase
    end
  endfunction

  task automatic issue(input logic [31:0] w);
    acc_req_i       = w;
    acc_req_valid_i = 1'b1;
    @(posedge clk_i);
    while (!acc_req_ready_o) @(posedge clk_i);
    ref_exec(w);
    accepted++;
    #10;
    acc_req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    @(posedge clk_i);
    while (resp_cnt != accepted) @(posedge clk_i);
    #10;
  endtask

  task automatic check_write();
    logic [`VEC_ADDR_W-1:0] a;
    elem_t                  d;
    mem[mem_addr_o % MEM_SZ] = mem_wdata_o;
    if (exp_addr.size() == 0) begin
      $display("Unexpected memory write at time %0t to address %h", $time, mem_addr_o);
      other_errs++;
    end else begin
      a = exp_addr.pop_front();
      d = exp_data.pop_front();
      if (mem_addr_o !== a) begin
        $display("FAIL t=%0t mem_addr_o got %h expected %h", $time, mem_addr_o, a);
        val_errs++;
      end
      if (mem_wdata_o !== d) begin
        $display("FAIL t=%0t mem_wdata_o got %h expected %h", $time, mem_wdata_o, d);
        val_errs++;
      end
    end
  endtask

  // Memory model with random grants, plus random response back-pressure
  always begin
    logic  rd;
    elem_t rdat;
    logic  gnt;
    logic  rsp;
    @(posedge clk_i);
    rd   = 1'b0;
    rdat = '0;
    if (rst_n_i && mem_req_o && mem_gnt_i) begin
      if (mem_we_o) begin
        check_write();
      end else begin
        rd   = 1'b1;
        rdat = mem[mem_addr_o % MEM_SZ];
      end
    end
    gnt = ($urandom % 4) != 0;
    rsp = !hold_resp && (($urandom % 4) != 0);
    #10;
    mem_gnt_i        = gnt;
    mem_rvalid_i     = rd;
    mem_rdata_i      = rdat;
    acc_resp_ready_i = rsp;
  end

  always @(posedge clk_i) begin
    if (rst_n_i && acc_resp_valid_o && acc_resp_ready_i) begin
      resp_cnt++;
    end
  end

  initial begin
    repeat (NR_INSNS * 64 + 200) @(posedge clk_i);
    $display("Timeout, the DUT did not finish the program in time");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(32'h550a_39d7));
    rst_n_i          = 1'b1;
    acc_req_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b0;
    mem_gnt_i        = 1'b0;
    mem_rvalid_i     = 1'b0;
    mem_rdata_i      = '0;
    for (int a = 0; a < MEM_SZ; a++) begin
      mem[a]     = fill_word(a);
      ref_mem[a] = fill_word(a);
    end
    #1;
    rst_n_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    if (!acc_req_ready_o) begin
      $display("Request port is not ready after reset");
      other_errs++;
    end
    #10;

    // Load, add, store
    issue(enc_mem(VLD, 1, 16));
    issue(enc_mem(VLD, 2, 40));
    issue(enc_add(3, 1, 2));
    issue(enc_mem(VST, 3, 600));
    wait_idle();

    // Load and store on unrelated registers overlap
    issue(enc_mem(VLD, 7, 100));
    issue(enc_mem(VST, 1, 700));
    wait_idle();

    // VADD reads a register still being loaded
    issue(enc_mem(VLD, 5, 200));
    issue(enc_add(6, 5, 2));
    issue(enc_mem(VST, 6, 800));
    wait_idle();

    // Two responses owed, so a third request must wait
    hold_resp = 1'b1;
    issue(enc_add(4, 1, 2));
    issue(enc_mem(VST, 4, 900));
    acc_req_i       = enc_add(0, 3, 3);
    acc_req_valid_i = 1'b1;
    repeat (40) @(posedge clk_i);
    if (acc_req_ready_o || !acc_resp_valid_o) begin
      $display("Back-pressure not seen, ready %b resp_valid %b", acc_req_ready_o,
               acc_resp_valid_o);
      other_errs++;
    end
    #10;
    hold_resp = 1'b0;
    issue(enc_add(0, 3, 3));
    wait_idle();

    // Random program after defining every register
    for (int v = 0; v < `VEC_NR_VREGS; v++) begin
      issue(enc_mem(VLD, v, $urandom % REGION));
    end
    for (int i = 0; i < 40; i++) begin
      case ($urandom % 3)
        0: issue(enc_add($urandom % 8, $urandom % 8, $urandom % 8));
        1: issue(enc_mem(VLD, $urandom % 8, $urandom % REGION));
        default: issue(enc_mem(VST, $urandom % 8, 512 + $urandom % REGION));
      endcase
    end
    wait_idle();

    repeat (20) @(posedge clk_i);
    if (resp_cnt != accepted) begin
      $display("Got %0d responses for %0d accepted requests", resp_cnt, accepted);
      other_errs++;
    end
    if (exp_addr.size() != 0) begin
      $display("%0d expected memory writes never happened", exp_addr.size());
      other_errs++;
    end
    $display("Errors: %0d value, %0d other, requests %0d, responses %0d",
             val_errs, other_errs, accepted, resp_cnt);
    if (val_errs + other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+hw
hw/vec_pkg.sv
hw/vec_ifs.sv
hw/vec_sequencer.sv
hw/vec_lane.sv
hw/vec_load_unit.sv
hw/vec_store_unit.sv
hw/mem_arbiter.sv
hw/vec_top.sv
bench/vec_sva.sv
bench/vec_tb.sv

// ==== Bender.yml ====
package:
  name: vec_coproc

sources:
  - include_dirs:
      - hw
    files:
      - hw/vec_pkg.sv
      - hw/vec_ifs.sv
      - hw/vec_sequencer.sv
      - hw/vec_lane.sv
      - hw/vec_load_unit.sv
      - hw/vec_store_unit.sv
      - hw/mem_arbiter.sv
      - hw/vec_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - bench/vec_sva.sv
      - bench/vec_tb.sv
